//--- Makefile
TB_TOP = cpu_pin_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --assert -f compile.f --top-module $(TB_TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TB_TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

lint:
	verilator --lint-only -Wall -Iverilog verilog/cpu_pkg.sv verilog/pin_bus_pkg.sv \
	  verilog/acc_cpu.sv verilog/byte_bus_sequencer.sv verilog/cpu_pin_top.sv \
	  --top-module cpu_pin_top

clean:
	rm -rf obj_dir

//--- compile.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/pin_bus_pkg.sv
verilog/acc_cpu.sv
verilog/byte_bus_sequencer.sv
verilog/cpu_pin_top.sv
dv/tb_clk_gen.sv
dv/cpu_pin_assert.sv
dv/cpu_pin_tb.sv

//--- dv/cpu_pin_assert.sv
// Pin protocol assertions, bound into every byte_bus_sequencer instance
module cpu_pin_assert (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       run,
  input logic                       bus_write,
  input pin_bus_pkg::frame_phase_e  phase,
  input pin_bus_pkg::pin_byte_t     pin_out,
  input pin_bus_pkg::pin_byte_t     pin_io_out,
  input pin_bus_pkg::pin_byte_t     pin_io_oe
);

  import pin_bus_pkg::*;

  // Output enable is all or nothing
  oe_all_or_none: assert property (@(posedge clk) disable iff (!rst_n)
    pin_io_oe inside {8'h00, 8'hFF})
    else $error("pin_io_oe has a partial value");

  // Write bytes are driven only in the address phases of a write frame
  oe_only_in_write_addr: assert property (@(posedge clk) disable iff (!rst_n)
    (pin_io_oe != 8'h00) |-> (bus_write && (phase inside {PH_ADDR0, PH_ADDR1, PH_ADDR2, PH_ADDR3})))
    else $error("pin_io_oe set outside a write address phase");

  // A stall freezes the registered pins and the phase
  hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (!run && (phase != PH_IDLE)) |=> ($stable(pin_out) && $stable(pin_io_out)
                                     && $stable(pin_io_oe) && $stable(phase)))
    else $error("pins moved while run was low");

endmodule

bind byte_bus_sequencer cpu_pin_assert i_pin_assert (
  .clk        (clk),
  .rst_n      (rst_n),
  .run        (run),
  .bus_write  (bus_write),
  .phase      (phase),
  .pin_out    (pin_out),
  .pin_io_out (pin_io_out),
  .pin_io_oe  (pin_io_oe)
);

//--- dv/cpu_pin_tb.sv
// Testbench for cpu_pin_top with an external memory model, a program table, store checks and a final report
`include "bridge_cfg.svh"

module cpu_pin_tb;

  import cpu_pkg::*;
  import pin_bus_pkg::*;

  localparam int NUM_TESTS   = 4;
  localparam int MAX_STORES  = 4;
  localparam int MAX_INSTR   = 14;                  // Executed instructions of the longest program
  localparam int CYCLE_LIMIT = MAX_INSTR * 20 * 2 + 100;
  localparam int HALT_WINDOW = 60;

  logic        clk;
  logic        gen_rst_n;
  logic        test_rst_n;
  logic        rst_n;
  logic        ena;
  logic [7:0]  ui_in;
  logic [7:0]  uo_out;
  logic [7:0]  uio_in;
  logic [7:0]  uio_out;
  logic [7:0]  uio_oe;

  // Stimulus table of programs, data words, expected stores and run modes
  cpu_word_t   prog_tab     [NUM_TESTS][16];
  cpu_word_t   data_tab     [NUM_TESTS][4];
  cpu_word_t   st_addr_tab  [NUM_TESTS][MAX_STORES];
  cpu_word_t   st_data_tab  [NUM_TESTS][MAX_STORES];
  int          st_count_tab [NUM_TESTS];
  logic        stall_tab    [NUM_TESTS];

  cpu_word_t   mem [256];     // External memory behind the pins
  cpu_word_t   store_addr_q [$];
  cpu_word_t   store_data_q [$];
  int          mphase;        // Model's view of the frame phase
  logic        m_write;
  cpu_word_t   m_addr;
  cpu_word_t   m_wdata;
  cpu_word_t   full_addr;
  cpu_word_t   full_wdata;
  int          frame_idx;
  int          last_start;
  cpu_opcode_e last_op;
  logic        m_halted;
  int          post_halt_frames;
  logic        stall_mode;
  logic [15:0] lfsr;
  logic [15:0] lfsr_a;
  logic [15:0] lfsr_b;
  int          cyc = 0;
  int          test_cycles = 0;
  int          errors;
  int          passed;

  assign rst_n = gen_rst_n & test_rst_n;

  tb_clk_gen i_clk_gen (
    .clk   (clk),
    .rst_n (gen_rst_n)
  );

  cpu_pin_top i_dut (
    .ui_in   (ui_in),
    .uo_out  (uo_out),
    .uio_in  (uio_in),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .ena     (ena),
    .clk     (clk),
    .rst_n   (rst_n)
  );

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // Taps 16, 14, 13, 11
  endfunction

  function automatic cpu_word_t enc(input cpu_opcode_e op, input logic [27:0] a);
    return {op, a};
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic build_table();
    for (int t = 0; t < NUM_TESTS; t++) begin
      for (int i = 0; i < 16; i++) begin
        prog_tab[t][i] = enc(HALT, 28'h0);
      end
      stall_tab[t] = (t >= 2);                 // Tests 2 and 3 repeat 0 and 1 with stalls
      if (t % 2 == 0) begin
        prog_tab[t][0] = enc(LOAD, 28'h20);
        prog_tab[t][1] = enc(ADD, 28'h21);
        prog_tab[t][2] = enc(STORE, 28'h30);
        prog_tab[t][3] = enc(SUB, 28'h22);
        prog_tab[t][4] = enc(STORE, 28'h31);
        prog_tab[t][5] = enc(HALT, 28'h0);
        data_tab[t] = '{32'hFFFF_FFF0, 32'h0000_0025, 32'h0000_0020, 32'h0};
        st_count_tab[t] = 2;
        st_addr_tab[t] = '{32'h30, 32'h31, 32'h0, 32'h0};
        st_data_tab[t] = '{32'h0000_0015, 32'hFFFF_FFF5, 32'h0, 32'h0};  // Both wrap
      end else begin
        prog_tab[t][0] = enc(LOAD, 28'h20);
        prog_tab[t][1] = enc(STORE, 28'h30);   // Loop head
        prog_tab[t][2] = enc(SUB, 28'h21);
        prog_tab[t][3] = enc(JZ, 28'h5);
        prog_tab[t][4] = enc(JUMP, 28'h1);
        prog_tab[t][5] = enc(STORE, 28'h31);
        prog_tab[t][6] = enc(HALT, 28'h0);
        data_tab[t] = '{32'h3, 32'h1, 32'h0, 32'h0};
        st_count_tab[t] = 4;
        st_addr_tab[t] = '{32'h30, 32'h30, 32'h30, 32'h31};
        st_data_tab[t] = '{32'h3, 32'h2, 32'h1, 32'h0};
      end
    end
  endtask

  // Run pin from two LFSR bits in stall mode so one cycle in four stalls
  always @(posedge clk) begin
    if (stall_mode && rst_n) begin
      lfsr_a = lfsr_step(lfsr);
      lfsr_b = lfsr_step(lfsr_a);
      lfsr  <= lfsr_b;
      ui_in <= {7'b0, lfsr_a[0] | lfsr_b[0]};
    end else begin
      ui_in <= 8'h01;
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // Memory model follows the frames from the status byte
  always @(posedge clk) begin
    if (!rst_n) begin
      mphase           <= 0;
      uio_in           <= '0;
      m_write          <= 1'b0;
      m_addr           <= '0;
      m_wdata          <= '0;
      frame_idx        <= 0;
      last_op          <= NOP;
      m_halted         <= 1'b0;
      post_halt_frames <= 0;
    end else if (ui_in[0]) begin
      if (mphase == 0) begin
        if (uo_out[`BRIDGE_STAT_VALID]) begin
          if (m_halted) begin
            post_halt_frames <= post_halt_frames + 1;
          end
          check("uo_out status", uo_out,
                (32'd1 << `BRIDGE_STAT_VALID)
                | (((frame_idx % 2 == 1) && (last_op == STORE)) << `BRIDGE_STAT_WRITE));
          if (!stall_mode && frame_idx > 0) begin
            check("frame_gap", cyc - last_start, 32'd10);
          end
          last_start <= cyc;
          m_write    <= uo_out[`BRIDGE_STAT_WRITE];
          mphase     <= 1;
        end
      end else if (mphase <= 4) begin
        check("uio_oe", uio_oe, m_write ? 32'hFF : 32'h00);
        if (!m_write) begin
          check("uio_out", uio_out, 32'h0);
        end
        full_addr = m_addr;
        full_addr[(mphase - 1) * 8 +: 8] = uo_out;
        full_wdata = m_wdata;
        full_wdata[(mphase - 1) * 8 +: 8] = uio_out;
        m_addr  <= full_addr;
        m_wdata <= full_wdata;
        if (mphase == 4) begin
          uio_in <= mem[full_addr[7:0]][7:0];  // Entering PH_DATA0
          if (frame_idx == 0) begin
            check("first_addr", full_addr, `BRIDGE_RESET_PC);
          end
        end
        mphase <= mphase + 1;
      end else if (mphase <= 7) begin
        uio_in <= mem[m_addr[7:0]][(mphase - 4) * 8 +: 8];
        mphase <= mphase + 1;
      end else begin
        uio_in    <= '0;
        mphase    <= 0;
        frame_idx <= frame_idx + 1;
        if (m_write) begin
          mem[m_addr[7:0]] = m_wdata;
          store_addr_q.push_back(m_addr);
          store_data_q.push_back(m_wdata);
        end
        if (frame_idx % 2 == 0) begin
          last_op <= cpu_opcode_e'(mem[m_addr[7:0]][31:28]);  // Fetch frame
        end else if (last_op == HALT) begin
          m_halted <= 1'b1;
        end
      end
    end
  end

  // Watchdog restarted by every test reset
  always @(posedge clk) begin
    if (!rst_n) begin
      test_cycles <= 0;
    end else begin
      test_cycles <= test_cycles + 1;
      if (test_cycles >= CYCLE_LIMIT) begin
        $display("Timeout: the test did not finish within %0d cycles", CYCLE_LIMIT);
        $display("SIMULATION FAILED");
        $finish;
      end
    end
  end

  task automatic run_test(input int t);
    int start_err;
    int n;
    start_err = errors;
    stall_mode <= 1'b0;
    repeat (2) @(posedge clk);
    test_rst_n <= 1'b0;
    for (int a = 0; a < 256; a++) begin
      mem[a] = 32'hC0DE_0000 | a;
    end
    for (int i = 0; i < 16; i++) begin
      mem[i] = prog_tab[t][i];
    end
    for (int i = 0; i < 4; i++) begin
      mem[32 + i] = data_tab[t][i];
    end
    @(posedge clk);
    test_rst_n <= 1'b1;
    // Second reset lands in the first write frame with all pins busy
    while (uo_out !== 8'h81) begin
      @(posedge clk);
    end
    test_rst_n <= 1'b0;
    store_addr_q.delete();
    store_data_q.delete();
    repeat (2) @(posedge clk);
    check("uo_out", uo_out, 32'h0);
    check("uio_out", uio_out, 32'h0);
    check("uio_oe", uio_oe, 32'h0);
    stall_mode <= stall_tab[t];
    test_rst_n <= 1'b1;
    @(posedge clk);
    while (!m_halted) begin
      @(posedge clk);
    end
    repeat (HALT_WINDOW) @(posedge clk);
    check("post_halt_frames", post_halt_frames, 32'h0);
    check("store_count", store_addr_q.size(), st_count_tab[t]);
    n = (store_addr_q.size() < st_count_tab[t]) ? store_addr_q.size() : st_count_tab[t];
    for (int i = 0; i < n; i++) begin
      check("store_addr", store_addr_q[i], st_addr_tab[t][i]);
      check("store_data", store_data_q[i], st_data_tab[t][i]);
    end
    if (errors == start_err) begin
      passed++;
    end
    $display("test %0d stall=%0d stores=%0d %s", t, stall_tab[t], store_addr_q.size(),
             (errors == start_err) ? "ok" : "bad");
  endtask

  initial begin
    ena        = 1'b1;
    ui_in      = 8'h01;
    uio_in     = 8'h00;
    test_rst_n = 1'b1;
    stall_mode = 1'b0;
    lfsr       = 16'd6575;
    errors     = 0;
    passed     = 0;
    build_table();
    @(posedge gen_rst_n);
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             NUM_TESTS, passed, NUM_TESTS - passed, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- dv/tb_clk_gen.sv
// Testbench clock with a period of 10 and a power-on reset held low for two cycles
module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;  // Released on the edge, like every other input
  end

endmodule

//--- verilog/acc_cpu.sv
// Accumulator processor, fetches and executes one instruction every two bus frames
`include "bridge_cfg.svh"

module acc_cpu (
  input  logic               clk,
  input  logic               rst_n,
  output logic               bus_req,
  output logic               bus_write,
  output cpu_pkg::cpu_word_t bus_addr,
  output cpu_pkg::cpu_word_t bus_wdata,
  input  cpu_pkg::cpu_word_t bus_rdata,
  input  logic               bus_done
);

  import cpu_pkg::*;

  cpu_state_e  state;
  cpu_word_t   pc;
  cpu_word_t   ir;        // Latched instruction
  cpu_word_t   acc;
  cpu_opcode_e opcode;
  cpu_word_t   operand;   // Zero-extended word address
  logic        req_q;
  logic        take_jump;

  assign opcode  = cpu_opcode_e'(ir[31:28]);
  assign operand = {4'b0000, ir[27:0]};

  // JZ tests the accumulator before this instruction's update
  assign take_jump = (opcode == JUMP) || ((opcode == JZ) && (acc == '0));

  // Request fields come from registers, so they stay put for the whole frame
  assign bus_req   = req_q;
  assign bus_addr  = (state == FETCH) ? pc : operand;
  assign bus_write = (state == EXEC) && (opcode == STORE);
  assign bus_wdata = acc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= FETCH;
      pc    <= `BRIDGE_RESET_PC;
      acc   <= '0;
      req_q <= 1'b0;
    end else begin
      req_q <= (state != HALTED);  // Stays high across frames
      if (bus_done && req_q) begin
        case (state)
          FETCH: begin
            state <= EXEC;
          end
          EXEC: begin
            case (opcode)
              LOAD:    acc <= bus_rdata;
              ADD:     acc <= acc + bus_rdata;  // Wraps modulo 2^32
              SUB:     acc <= acc - bus_rdata;
              default: acc <= acc;              // Read data is dropped
            endcase
            if (take_jump) begin
              pc <= operand;
            end else begin
              pc <= pc + 32'd1;
            end
            if (opcode == HALT) begin
              state <= HALTED;
              req_q <= 1'b0;  // No further frames
            end else begin
              state <= FETCH;
            end
          end
          default: begin
            state <= HALTED;
          end
        endcase
      end
    end
  end

  // Instruction word is captured at the end of the fetch frame
  always_ff @(posedge clk) begin
    if (bus_done && req_q && (state == FETCH)) begin
      ir <= bus_rdata;
    end
  end

endmodule

//--- verilog/bridge_cfg.svh
// Fixed frame constants and status byte bit positions, included by the RTL and the testbench
`ifndef BRIDGE_CFG_SVH
`define BRIDGE_CFG_SVH

// Word address of the first instruction fetched after reset
`define BRIDGE_RESET_PC 32'h0000_0000

// Number of the last frame phase (PH_DATA3), the edge after it closes the frame
`define BRIDGE_LAST_PHASE 4'd8

// Status byte shown on uo_out while the sequencer waits in PH_IDLE
`define BRIDGE_STAT_VALID 7
`define BRIDGE_STAT_WRITE 0

`endif

//--- verilog/byte_bus_sequencer.sv
// Frame sequencer, carries one 32-bit bus access over two 8-bit pin groups per frame
`include "bridge_cfg.svh"

module byte_bus_sequencer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   run,
  input  logic                   bus_req,
  input  logic                   bus_write,
  input  cpu_pkg::cpu_word_t     bus_addr,
  input  cpu_pkg::cpu_word_t     bus_wdata,
  output cpu_pkg::cpu_word_t     bus_rdata,
  output logic                   bus_done,
  output pin_bus_pkg::pin_byte_t pin_out,
  output pin_bus_pkg::pin_byte_t pin_io_out,
  output pin_bus_pkg::pin_byte_t pin_io_oe,
  input  pin_bus_pkg::pin_byte_t pin_io_in
);

  import cpu_pkg::*;
  import pin_bus_pkg::*;

  frame_phase_e phase;
  frame_phase_e phase_next;
  pin_byte_t    out_q;
  pin_byte_t    io_out_q;
  pin_byte_t    io_oe_q;
  pin_byte_t    status;
  pin_byte_t    addr_byte;
  pin_byte_t    data_byte;
  cpu_word_t    rdata_q;
  logic         done_q;
  logic         addr_next;  // Next phase drives address bytes

  // Done cycle still carries the old request, so no start there
  always_comb begin
    phase_next = phase;
    if (phase == PH_IDLE) begin
      if (bus_req && !done_q) begin
        phase_next = PH_ADDR0;
      end
    end else if (phase == frame_phase_e'(`BRIDGE_LAST_PHASE)) begin
      phase_next = PH_IDLE;
    end else begin
      phase_next = frame_phase_e'(phase + 4'd1);
    end
  end

  assign addr_next = phase_next inside {PH_ADDR0, PH_ADDR1, PH_ADDR2, PH_ADDR3};

  // Byte for the phase being entered, lowest first
  always_comb begin
    addr_byte = '0;
    data_byte = '0;
    case (phase_next)
      PH_ADDR0: begin
        addr_byte = bus_addr[7:0];
        data_byte = bus_wdata[7:0];
      end
      PH_ADDR1: begin
        addr_byte = bus_addr[15:8];
        data_byte = bus_wdata[15:8];
      end
      PH_ADDR2: begin
        addr_byte = bus_addr[23:16];
        data_byte = bus_wdata[23:16];
      end
      PH_ADDR3: begin
        addr_byte = bus_addr[31:24];
        data_byte = bus_wdata[31:24];
      end
      default: begin
        addr_byte = '0;
        data_byte = '0;
      end
    endcase
  end

  always_comb begin
    status                     = '0;
    status[`BRIDGE_STAT_VALID] = bus_req && !done_q;
    status[`BRIDGE_STAT_WRITE] = bus_req && !done_q && bus_write;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase    <= PH_IDLE;
      out_q    <= '0;
      io_out_q <= '0;
      io_oe_q  <= '0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;  // One-cycle pulse
      if (run) begin
        phase    <= phase_next;
        out_q    <= addr_byte;
        io_out_q <= bus_write ? data_byte : '0;
        io_oe_q  <= (bus_write && addr_next) ? '1 : '0;
        if (phase == frame_phase_e'(`BRIDGE_LAST_PHASE)) begin
          done_q <= 1'b1;
        end
      end
    end
  end

  // Shift in from the top, so byte 0 ends at the bottom after four phases
  always_ff @(posedge clk) begin
    if (run && (phase inside {PH_DATA0, PH_DATA1, PH_DATA2, PH_DATA3})) begin
      rdata_q <= {pin_io_in, rdata_q[31:8]};
    end
  end

  assign pin_out    = (phase == PH_IDLE) ? status : out_q;
  assign pin_io_out = io_out_q;
  assign pin_io_oe  = io_oe_q;
  assign bus_rdata  = rdata_q;
  assign bus_done   = done_q;

endmodule

//--- verilog/cpu_pin_top.sv
// Top level with the tile pin set, joins the accumulator processor to the pin frame sequencer
module cpu_pin_top (
  input  logic [7:0] ui_in,    // Bit 0 is run, low stalls the frame
  output logic [7:0] uo_out,   // Status and address bytes
  input  logic [7:0] uio_in,   // Read data bytes
  output logic [7:0] uio_out,  // Write data bytes
  output logic [7:0] uio_oe,   // All ones while write data is driven
  input  logic       ena,
  input  logic       clk,
  input  logic       rst_n
);

  import cpu_pkg::*;

  logic      bus_req;
  logic      bus_write;
  logic      bus_done;
  cpu_word_t bus_addr;
  cpu_word_t bus_wdata;
  cpu_word_t bus_rdata;
  logic      unused_inputs;

  acc_cpu i_cpu (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus_req   (bus_req),
    .bus_write (bus_write),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata),
    .bus_done  (bus_done)
  );

  byte_bus_sequencer i_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (ui_in[0]),
    .bus_req    (bus_req),
    .bus_write  (bus_write),
    .bus_addr   (bus_addr),
    .bus_wdata  (bus_wdata),
    .bus_rdata  (bus_rdata),
    .bus_done   (bus_done),
    .pin_out    (uo_out),
    .pin_io_out (uio_out),
    .pin_io_oe  (uio_oe),
    .pin_io_in  (uio_in)
  );

  // Tile inputs with no function in this design
  assign unused_inputs = &{ena, ui_in[7:1], 1'b0};

endmodule

//--- verilog/cpu_pkg.sv
// Processor types shared by the accumulator core, the top level and the testbench
package cpu_pkg;

  // Addresses, instructions and data are all one word wide
  typedef logic [31:0] cpu_word_t;

  // Opcode lives in instruction bits 31:28
  typedef enum logic [3:0] {
    NOP   = 4'd0,
    LOAD  = 4'd1,
    STORE = 4'd2,
    ADD   = 4'd3,
    SUB   = 4'd4,
    JUMP  = 4'd5,
    JZ    = 4'd6,
    HALT  = 4'd15
  } cpu_opcode_e;

  // One bus frame per state, HALTED is final
  typedef enum logic [1:0] {
    FETCH,
    EXEC,
    HALTED
  } cpu_state_e;

endpackage

//--- verilog/pin_bus_pkg.sv
// Byte-serial pin protocol types used by the frame sequencer and the testbench
package pin_bus_pkg;

  // One pin group is eight bits wide
  typedef logic [7:0] pin_byte_t;

  // Phases of one frame, each lasts one cycle with run high
  typedef enum logic [3:0] {
    PH_IDLE  = 4'd0,  // Status byte, waiting for a request
    PH_ADDR0 = 4'd1,  // Address and write bytes, lowest first
    PH_ADDR1 = 4'd2,
    PH_ADDR2 = 4'd3,
    PH_ADDR3 = 4'd4,
    PH_DATA0 = 4'd5,  // Read bytes sampled on the closing edge
    PH_DATA1 = 4'd6,
    PH_DATA2 = 4'd7,
    PH_DATA3 = 4'd8
  } frame_phase_e;

endpackage
